/* Makefile */
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_mem_subsys
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := src/wb_sys_pkg.sv src/wb_arbiter.sv src/wb_pma_decode.sv src/wb_ram.sv \
        src/wb_mmio_catch.sv src/wb_mem_subsys.sv \
        verif/wb_mem_subsys_props.sv verif/tb_wb_mem_subsys.sv

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
src/wb_sys_pkg.sv
src/wb_arbiter.sv
src/wb_pma_decode.sv
src/wb_ram.sv
src/wb_mmio_catch.sv
src/wb_mem_subsys.sv
verif/wb_mem_subsys_props.sv
verif/tb_wb_mem_subsys.sv

/* src/wb_arbiter.sv */
// Round-robin arbiter joining the instruction and data Wishbone masters onto one shared bus
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input  wire                      HCLK,
  input  wire                      rst_n_i,
  input  wire wb_sys_pkg::wb_req_t ins_req_i,
  output wb_sys_pkg::wb_rsp_t      ins_rsp_o,
  input  wire wb_sys_pkg::wb_req_t dat_req_i,
  output wb_sys_pkg::wb_rsp_t      dat_rsp_o,
  output wb_sys_pkg::wb_req_t      bus_req_o,
  output wb_sys_pkg::mst_id_t      bus_mst_o,
  input  wire wb_sys_pkg::wb_rsp_t bus_rsp_i
);

  wb_sys_pkg::arb_state_t state_q, state_d;
  // Owner of the current or most recent grant
  wb_sys_pkg::mst_id_t    last_q, last_d;
  wb_sys_pkg::mst_id_t    pick;

  ////////////////////////////////////////
  // Grant FSM
  ////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    last_d  = last_q;
    pick    = last_q;
    case (state_q)
      wb_sys_pkg::ARB_IDLE: begin
        if (ins_req_i.cyc || dat_req_i.cyc) begin
          // Tie goes to the port that did not own the bus last
          if (ins_req_i.cyc && dat_req_i.cyc) begin
            pick = ~last_q;
          end else begin
            pick = dat_req_i.cyc;
          end
          state_d = pick ? wb_sys_pkg::ARB_DAT : wb_sys_pkg::ARB_INS;
          last_d  = pick;
        end
      end
      // Owner holds the bus for as long as cyc stays high
      wb_sys_pkg::ARB_INS: if (!ins_req_i.cyc) state_d = wb_sys_pkg::ARB_IDLE;
      wb_sys_pkg::ARB_DAT: if (!dat_req_i.cyc) state_d = wb_sys_pkg::ARB_IDLE;
      default: state_d = wb_sys_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      state_q <= wb_sys_pkg::ARB_IDLE;
      // Instruction port wins the first tie
      last_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

  ////////////////////////////////////////
  // Request mux and response steering
  ////////////////////////////////////////
  always_comb begin
    // Idle bus carries no strobe
    bus_req_o = '0;
    ins_rsp_o = '0;
    dat_rsp_o = '0;
    case (state_q)
      wb_sys_pkg::ARB_INS: begin
        bus_req_o = ins_req_i;
        ins_rsp_o = bus_rsp_i;
      end
      wb_sys_pkg::ARB_DAT: begin
        bus_req_o = dat_req_i;
        dat_rsp_o = bus_rsp_i;
      end
      default: ;
    endcase
  end

  // Valid while a grant is held
  assign bus_mst_o = last_q;

endmodule

`default_nettype wire

/* src/wb_mem_subsys.sv */
// Memory subsystem top with two Wishbone masters sharing RAM and MMIO through an arbiter
`timescale 1ns/1ps
`default_nettype none

module wb_mem_subsys #(
  parameter int               RAM_AW      = 10,
  parameter int               MEM_LATENCY = 1,
  parameter wb_sys_pkg::adr_t TOHOST      = 32'h8000_1000,
  parameter wb_sys_pkg::adr_t UART_TX     = 32'h8000_1080
) (
  input  wire                      HCLK,
  input  wire                      rst_n_i,
  input  wire wb_sys_pkg::wb_req_t ins_req_i,
  output wb_sys_pkg::wb_rsp_t      ins_rsp_o,
  input  wire wb_sys_pkg::wb_req_t dat_req_i,
  output wb_sys_pkg::wb_rsp_t      dat_rsp_o,
  output logic                     tohost_valid_o,
  output wb_sys_pkg::dat_t         tohost_data_o,
  output logic                     uart_valid_o,
  output logic [7:0]               uart_char_o
);

  ////////////////////////////////////////
  // Shared bus and slave links
  ////////////////////////////////////////
  wb_sys_pkg::wb_req_t bus_req, ram_req, mmio_req;
  wb_sys_pkg::wb_rsp_t bus_rsp, ram_rsp, mmio_rsp;
  wb_sys_pkg::mst_id_t bus_mst;

  // Two masters onto one bus
  wb_arbiter u_arbiter (
    .HCLK      ( HCLK      ),
    .rst_n_i   ( rst_n_i   ),
    .ins_req_i ( ins_req_i ),
    .ins_rsp_o ( ins_rsp_o ),
    .dat_req_i ( dat_req_i ),
    .dat_rsp_o ( dat_rsp_o ),
    .bus_req_o ( bus_req   ),
    .bus_mst_o ( bus_mst   ),
    .bus_rsp_i ( bus_rsp   )
  );

  // Region check and routing
  wb_pma_decode #(
    .RAM_AW  ( RAM_AW  ),
    .TOHOST  ( TOHOST  ),
    .UART_TX ( UART_TX )
  ) u_pma_decode (
    .HCLK       ( HCLK     ),
    .rst_n_i    ( rst_n_i  ),
    .bus_req_i  ( bus_req  ),
    .bus_mst_i  ( bus_mst  ),
    .bus_rsp_o  ( bus_rsp  ),
    .ram_req_o  ( ram_req  ),
    .ram_rsp_i  ( ram_rsp  ),
    .mmio_req_o ( mmio_req ),
    .mmio_rsp_i ( mmio_rsp )
  );

  wb_ram #(
    .RAM_AW      ( RAM_AW      ),
    .MEM_LATENCY ( MEM_LATENCY )
  ) u_ram (
    .HCLK    ( HCLK    ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( ram_req ),
    .rsp_o   ( ram_rsp )
  );

  // Host-side catch of TOHOST and UART writes
  wb_mmio_catch #(
    .TOHOST  ( TOHOST  ),
    .UART_TX ( UART_TX )
  ) u_mmio_catch (
    .HCLK           ( HCLK           ),
    .rst_n_i        ( rst_n_i        ),
    .req_i          ( mmio_req       ),
    .rsp_o          ( mmio_rsp       ),
    .tohost_valid_o ( tohost_valid_o ),
    .tohost_data_o  ( tohost_data_o  ),
    .uart_valid_o   ( uart_valid_o   ),
    .uart_char_o    ( uart_char_o    )
  );

endmodule

`default_nettype wire

/* src/wb_mmio_catch.sv */
// TOHOST and UART transmit registers with single-cycle host notification pulses
`timescale 1ns/1ps
`default_nettype none

module wb_mmio_catch #(
  parameter wb_sys_pkg::adr_t TOHOST  = 32'h8000_1000,
  parameter wb_sys_pkg::adr_t UART_TX = 32'h8000_1080
) (
  input  wire                      HCLK,
  input  wire                      rst_n_i,
  input  wire wb_sys_pkg::wb_req_t req_i,
  output wb_sys_pkg::wb_rsp_t      rsp_o,
  output logic                     tohost_valid_o,
  output wb_sys_pkg::dat_t         tohost_data_o,
  output logic                     uart_valid_o,
  output logic [7:0]               uart_char_o
);

  wb_sys_pkg::dat_t tohost_q, rdat_q;
  logic [7:0]       uart_char_q;
  logic             ack_q, tohost_valid_q, uart_valid_q;
  logic             hit_tohost, hit_uart, ack_go;

  assign hit_tohost = (req_i.adr == TOHOST);
  assign hit_uart   = (req_i.adr == UART_TX);
  // One ack per strobe
  assign ack_go     = req_i.cyc && req_i.stb && !ack_q;

  ////////////////////////////////////////
  // Handshake and pulses
  ////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      ack_q          <= 1'b0;
      tohost_valid_q <= 1'b0;
      uart_valid_q   <= 1'b0;
    end else begin
      ack_q          <= ack_go;
      tohost_valid_q <= ack_go && req_i.we && hit_tohost;
      uart_valid_q   <= ack_go && req_i.we && hit_uart && req_i.sel[0];
    end
  end

  // Registers, updated with the ack
  always_ff @(posedge HCLK) begin
    if (ack_go) begin
      rdat_q <= hit_tohost ? tohost_q : '0;
      if (req_i.we && hit_tohost) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.sel[b]) tohost_q[8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
      if (req_i.we && hit_uart) uart_char_q <= req_i.dat[7:0];
    end
  end

  assign rsp_o.dat      = rdat_q;
  assign rsp_o.ack      = ack_q;
  assign rsp_o.err      = 1'b0;
  assign tohost_valid_o = tohost_valid_q;
  assign tohost_data_o  = tohost_q;
  assign uart_valid_o   = uart_valid_q;
  assign uart_char_o    = uart_char_q;

endmodule

`default_nettype wire

/* src/wb_pma_decode.sv */
// Memory attribute check and slave routing for the shared Wishbone bus
`timescale 1ns/1ps
`default_nettype none

module wb_pma_decode #(
  parameter int               RAM_AW  = 10,
  parameter wb_sys_pkg::adr_t TOHOST  = 32'h8000_1000,
  parameter wb_sys_pkg::adr_t UART_TX = 32'h8000_1080
) (
  input  wire                      HCLK,
  input  wire                      rst_n_i,
  input  wire wb_sys_pkg::wb_req_t bus_req_i,
  input  wire wb_sys_pkg::mst_id_t bus_mst_i,
  output wb_sys_pkg::wb_rsp_t      bus_rsp_o,
  output wb_sys_pkg::wb_req_t      ram_req_o,
  input  wire wb_sys_pkg::wb_rsp_t ram_rsp_i,
  output wb_sys_pkg::wb_req_t      mmio_req_o,
  input  wire wb_sys_pkg::wb_rsp_t mmio_rsp_i
);

  logic hit_ram, hit_io, is_ins, ram_ok, io_ok;
  logic req_act, rej_act;
  logic err_q, err_seen_q;

  ////////////////////////////////////////
  // Region check
  ////////////////////////////////////////
  // RAM spans 4 * 2**RAM_AW bytes from the aligned base
  assign hit_ram = (bus_req_i.adr >> (RAM_AW + 2)) == (wb_sys_pkg::RAM_BASE >> (RAM_AW + 2));
  assign hit_io  = (bus_req_i.adr == TOHOST) || (bus_req_i.adr == UART_TX);
  assign is_ins  = (bus_mst_i == 1'b0);

  // Fetch port may only read main memory
  assign ram_ok  = hit_ram && !(is_ins && bus_req_i.we);
  // IO words are for the data port only
  assign io_ok   = hit_io && !is_ins;

  assign req_act = bus_req_i.cyc && bus_req_i.stb;
  assign rej_act = req_act && !ram_ok && !io_ok;

  // Routed requests, strobe gated per slave
  always_comb begin
    ram_req_o      = bus_req_i;
    ram_req_o.stb  = bus_req_i.stb && ram_ok;
    mmio_req_o     = bus_req_i;
    mmio_req_o.stb = bus_req_i.stb && io_ok;
  end

  ////////////////////////////////////////
  // Error pulse
  ////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      err_q      <= 1'b0;
      err_seen_q <= 1'b0;
    end else begin
      err_q      <= rej_act && !err_q && !err_seen_q;
      // Held until the master lets go of stb
      err_seen_q <= rej_act && (err_seen_q || err_q);
    end
  end

  // Merge slave answers with our own error
  assign bus_rsp_o.dat = ram_rsp_i.ack ? ram_rsp_i.dat : mmio_rsp_i.dat;
  assign bus_rsp_o.ack = ram_rsp_i.ack || mmio_rsp_i.ack;
  assign bus_rsp_o.err = err_q || ram_rsp_i.err || mmio_rsp_i.err;

endmodule

`default_nettype wire

/* src/wb_ram.sv */
// Word RAM on Wishbone with byte selects and a fixed number of wait cycles
`timescale 1ns/1ps
`default_nettype none

module wb_ram #(
  parameter int RAM_AW      = 10,
  parameter int MEM_LATENCY = 1
) (
  input  wire                      HCLK,
  input  wire                      rst_n_i,
  input  wire wb_sys_pkg::wb_req_t req_i,
  output wb_sys_pkg::wb_rsp_t      rsp_o
);

  // Enough bits to hold MEM_LATENCY-1
  localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  wb_sys_pkg::dat_t       mem_q [2**RAM_AW];
  wb_sys_pkg::dat_t       rdat_q;
  wb_sys_pkg::ram_state_t state_q;
  logic [CNT_W-1:0]       cnt_q;
  logic [RAM_AW-1:0]      idx;
  logic                   req_act;
  logic                   mem_go;

  assign idx     = req_i.adr[RAM_AW+1:2];
  assign req_act = req_i.cyc && req_i.stb;
  // Last wait cycle, access the array
  assign mem_go  = (state_q == wb_sys_pkg::RAM_WAIT) && req_act && (cnt_q == '0);

  ////////////////////////////////////////
  // Latency FSM
  ////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      state_q <= wb_sys_pkg::RAM_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        wb_sys_pkg::RAM_IDLE: begin
          if (req_act) begin
            state_q <= wb_sys_pkg::RAM_WAIT;
            cnt_q   <= CNT_W'(MEM_LATENCY - 1);
          end
        end
        wb_sys_pkg::RAM_WAIT: begin
          // Dropped strobe abandons the access
          if (!req_act) begin
            state_q <= wb_sys_pkg::RAM_IDLE;
          end else if (cnt_q == '0) begin
            state_q <= wb_sys_pkg::RAM_ACK;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        wb_sys_pkg::RAM_ACK: state_q <= wb_sys_pkg::RAM_IDLE;
        default: state_q <= wb_sys_pkg::RAM_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (mem_go) begin
      rdat_q <= mem_q[idx];
      if (req_i.we) begin
        // Only the selected byte lanes
        for (int b = 0; b < 4; b++) begin
          if (req_i.sel[b]) mem_q[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = (state_q == wb_sys_pkg::RAM_ACK);
  assign rsp_o.err = 1'b0;

endmodule

`default_nettype wire

/* src/wb_sys_pkg.sv */
// Shared Wishbone types, memory region constants and FSM encodings of the memory subsystem
`default_nettype none

package wb_sys_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////
  typedef logic [31:0] adr_t;
  typedef logic [31:0] dat_t;
  typedef logic [3:0]  sel_t;
  // 0 is the instruction port, 1 the data port
  typedef logic        mst_id_t;

  ////////////////////////////////////////
  // Bus bundles
  ////////////////////////////////////////
  // Master to slave
  typedef struct packed {
    adr_t adr;
    dat_t dat;
    sel_t sel;
    logic we;
    logic cyc;
    logic stb;
  } wb_req_t;

  // Slave to master, ack and err are single-cycle pulses
  typedef struct packed {
    dat_t dat;
    logic ack;
    logic err;
  } wb_rsp_t;

  // Start of the main memory region
  localparam adr_t RAM_BASE = 32'h8000_0000;

  ////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_INS,
    ARB_DAT
  } arb_state_t;

  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_WAIT,
    RAM_ACK
  } ram_state_t;

endpackage

`default_nettype wire

/* verif/tb_wb_mem_subsys.sv */
// Directed testbench for the Wishbone memory subsystem that plays both ports of the core
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem_subsys;

  localparam int                  RAM_AW      = 8;
  localparam int                  MEM_LATENCY = 2;
  localparam wb_sys_pkg::adr_t    TOHOST      = 32'h8000_1000;
  localparam wb_sys_pkg::adr_t    UART_TX     = 32'h8000_1080;
  localparam wb_sys_pkg::mst_id_t INS         = 1'b0;
  localparam wb_sys_pkg::mst_id_t DAT         = 1'b1;
  // Word-aligned offset mask and size of the RAM region
  localparam wb_sys_pkg::adr_t    RAM_MASK    = (4 << RAM_AW) - 4;
  localparam wb_sys_pkg::adr_t    RAM_BYTES   = 4 << RAM_AW;
  // Random rounds of test 1 with three accesses each
  localparam int                  N_RW        = 12;
  localparam int                  N_ACC       = 3 * N_RW + 17;
  localparam int                  WD_CYCLES   = N_ACC * (MEM_LATENCY + 6) + 200;

  logic                HCLK = 1'b0;
  logic                rst_n;
  wb_sys_pkg::wb_req_t ins_req, dat_req;
  wb_sys_pkg::wb_rsp_t ins_rsp, dat_rsp;
  logic                tohost_valid, uart_valid;
  wb_sys_pkg::dat_t    tohost_data;
  logic [7:0]          uart_char;

  // Shadow copy of the RAM
  wb_sys_pkg::dat_t    shadow [2**RAM_AW];
  int                  errors = 0;
  int                  tests = 0;
  int                  tohost_cnt = 0;
  int                  uart_cnt = 0;
  wb_sys_pkg::dat_t    tohost_seen;
  logic [7:0]          uart_seen;

  wb_mem_subsys #(
    .RAM_AW      ( RAM_AW      ),
    .MEM_LATENCY ( MEM_LATENCY ),
    .TOHOST      ( TOHOST      ),
    .UART_TX     ( UART_TX     )
  ) wb_mem_subsys_i (
    .HCLK           ( HCLK         ),
    .rst_n_i        ( rst_n        ),
    .ins_req_i      ( ins_req      ),
    .ins_rsp_o      ( ins_rsp      ),
    .dat_req_i      ( dat_req      ),
    .dat_rsp_o      ( dat_rsp      ),
    .tohost_valid_o ( tohost_valid ),
    .tohost_data_o  ( tohost_data  ),
    .uart_valid_o   ( uart_valid   ),
    .uart_char_o    ( uart_char    )
  );

  always #5 HCLK = ~HCLK;

  // Host pulses sampled mid-cycle
  always @(negedge HCLK) begin
    if (tohost_valid) begin
      tohost_cnt  <= tohost_cnt + 1;
      tohost_seen <= tohost_data;
    end
    if (uart_valid) begin
      uart_cnt  <= uart_cnt + 1;
      uart_seen <= uart_char;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_dat(input wb_sys_pkg::dat_t got, input wb_sys_pkg::dat_t exp,
                           input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_char(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Either ack alone or err alone
  task automatic expect_outcome(input wb_sys_pkg::wb_rsp_t rsp, input logic exp_ack,
                                input string what);
    check_flag(rsp.ack, exp_ack, {what, " ack"});
    check_flag(rsp.err, !exp_ack, {what, " err"});
  endtask

  ////////////////////////////////////////
  // Master side
  ////////////////////////////////////////
  // One classic cycle held until ack or err
  task automatic wb_access(input wb_sys_pkg::mst_id_t port, input wb_sys_pkg::adr_t adr,
                           input wb_sys_pkg::dat_t wdat, input wb_sys_pkg::sel_t sel,
                           input logic we, output wb_sys_pkg::wb_rsp_t rsp,
                           output time t_done);
    wb_sys_pkg::wb_req_t req;
    req = '{adr: adr, dat: wdat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
    @(negedge HCLK);
    if (port == DAT) dat_req = req;
    else ins_req = req;
    do begin
      @(negedge HCLK);
      rsp = (port == DAT) ? dat_rsp : ins_rsp;
    end while (!(rsp.ack || rsp.err));
    // Drop stb and cyc together
    if (port == DAT) dat_req = '0;
    else ins_req = '0;
    t_done = $time;
  endtask

  task automatic write_ram(input wb_sys_pkg::adr_t adr, input wb_sys_pkg::dat_t d,
                           input wb_sys_pkg::sel_t sel);
    wb_sys_pkg::wb_rsp_t rsp;
    time                 t;
    wb_access(DAT, adr, d, sel, 1'b1, rsp, t);
    expect_outcome(rsp, 1'b1, "RAM write");
    // Byte lanes named by sel only
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) shadow[adr[RAM_AW+1:2]][8*b +: 8] = d[8*b +: 8];
    end
  endtask

  task automatic read_check(input wb_sys_pkg::mst_id_t port, input wb_sys_pkg::adr_t adr);
    wb_sys_pkg::wb_rsp_t rsp;
    time                 t;
    wb_access(port, adr, '0, 4'hF, 1'b0, rsp, t);
    expect_outcome(rsp, 1'b1, "RAM read");
    check_dat(rsp.dat, shadow[adr[RAM_AW+1:2]], "RAM read data");
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("Test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_ram_random();
    wb_sys_pkg::adr_t adr;
    logic [31:0]      rnd;
    for (int i = 0; i < N_RW; i++) begin
      adr = wb_sys_pkg::RAM_BASE | ($urandom() & RAM_MASK);
      // Full word first so every lane is known
      write_ram(adr, $urandom(), 4'hF);
      rnd = $urandom();
      write_ram(adr, $urandom(), rnd[3:0]);
      read_check(DAT, adr);
    end
  endtask

  task automatic test_fetch_after_write();
    write_ram(wb_sys_pkg::RAM_BASE, $urandom(), 4'hF);
    read_check(INS, wb_sys_pkg::RAM_BASE);
  endtask

  task automatic test_errors();
    wb_sys_pkg::wb_rsp_t rsp;
    time                 t;
    // Just past the RAM end where a wrong decode aliases word 0
    wb_access(DAT, wb_sys_pkg::RAM_BASE + RAM_BYTES, 32'hdead_beef, 4'hF, 1'b1, rsp, t);
    expect_outcome(rsp, 1'b0, "unmapped write");
    read_check(DAT, wb_sys_pkg::RAM_BASE);
    wb_access(INS, TOHOST, '0, 4'hF, 1'b0, rsp, t);
    expect_outcome(rsp, 1'b0, "fetch from TOHOST");
    wb_access(INS, wb_sys_pkg::RAM_BASE, 32'h1234_5678, 4'hF, 1'b1, rsp, t);
    expect_outcome(rsp, 1'b0, "instruction-port write");
    read_check(DAT, wb_sys_pkg::RAM_BASE);
  endtask

  task automatic test_mmio();
    wb_sys_pkg::wb_rsp_t rsp;
    wb_sys_pkg::dat_t    word;
    int                  cnt0;
    time                 t;
    word = $urandom();
    cnt0 = tohost_cnt;
    wb_access(DAT, TOHOST, word, 4'hF, 1'b1, rsp, t);
    expect_outcome(rsp, 1'b1, "TOHOST write");
    // Settle time for the pulse monitor
    repeat (3) @(negedge HCLK);
    check_flag(tohost_cnt == cnt0 + 1, 1'b1, "single TOHOST pulse");
    check_dat(tohost_seen, word, "TOHOST pulse data");
    wb_access(DAT, TOHOST, '0, 4'hF, 1'b0, rsp, t);
    expect_outcome(rsp, 1'b1, "TOHOST read");
    check_dat(rsp.dat, word, "TOHOST read data");
    word = $urandom();
    cnt0 = uart_cnt;
    wb_access(DAT, UART_TX, word, 4'hF, 1'b1, rsp, t);
    expect_outcome(rsp, 1'b1, "UART write");
    repeat (3) @(negedge HCLK);
    check_flag(uart_cnt == cnt0 + 1, 1'b1, "single UART pulse");
    check_char(uart_seen, word[7:0], "UART byte");
  endtask

  task automatic test_contention();
    wb_sys_pkg::adr_t    adr_a, adr_b;
    wb_sys_pkg::wb_rsp_t rsp_i, rsp_d;
    time                 t_i, t_d;
    logic [1:0]          ins_first;
    adr_a = wb_sys_pkg::RAM_BASE + 32'h40;
    adr_b = wb_sys_pkg::RAM_BASE + 32'h80;
    write_ram(adr_a, $urandom(), 4'hF);
    write_ram(adr_b, $urandom(), 4'hF);
    for (int p = 0; p < 2; p++) begin
      // Same falling edge on both ports
      fork
        wb_access(INS, p ? adr_b : adr_a, '0, 4'hF, 1'b0, rsp_i, t_i);
        wb_access(DAT, p ? adr_a : adr_b, '0, 4'hF, 1'b0, rsp_d, t_d);
      join
      expect_outcome(rsp_i, 1'b1, "contended fetch");
      expect_outcome(rsp_d, 1'b1, "contended load");
      check_dat(rsp_i.dat, shadow[p ? adr_b[RAM_AW+1:2] : adr_a[RAM_AW+1:2]], "fetch data");
      check_dat(rsp_d.dat, shadow[p ? adr_a[RAM_AW+1:2] : adr_b[RAM_AW+1:2]], "load data");
      check_flag(t_i != t_d, 1'b1, "responses in separate cycles");
      ins_first[p] = (t_i < t_d);
      // A lone fetch hands ownership back to the instruction port
      if (p == 0) read_check(INS, adr_a);
    end
    // Tie goes to the port that did not own the bus last
    check_flag(ins_first[0], 1'b1, "first pair grant order");
    check_flag(ins_first[1], 1'b0, "second pair grant order");
  endtask

  ////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////
  initial begin
    int e0;
    void'($urandom(32'h66ad));
    rst_n   = 1'b0;
    ins_req = '0;
    dat_req = '0;
    repeat (4) @(posedge HCLK);
    @(negedge HCLK);
    rst_n = 1'b1;
    e0 = errors;
    test_ram_random();
    report_test("random RAM write and read", e0);
    e0 = errors;
    test_fetch_after_write();
    report_test("fetch after data write", e0);
    e0 = errors;
    test_errors();
    report_test("error responses", e0);
    e0 = errors;
    test_mmio();
    report_test("TOHOST and UART", e0);
    e0 = errors;
    test_contention();
    report_test("port contention", e0);
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge HCLK);
    $display("Timeout: the tests did not finish within %0d cycles", WD_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/wb_mem_subsys_props.sv */
// Protocol assertions on the two Wishbone ports of the memory subsystem
`timescale 1ns/1ps
`default_nettype none

module wb_mem_subsys_props (
  input wire                      HCLK,
  input wire                      rst_n_i,
  input wire wb_sys_pkg::wb_req_t ins_req_i,
  input wire wb_sys_pkg::wb_rsp_t ins_rsp_i,
  input wire wb_sys_pkg::wb_req_t dat_req_i,
  input wire wb_sys_pkg::wb_rsp_t dat_rsp_i
);

  // Ack and err exclusive on each port
  a_ins_excl: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    !(ins_rsp_i.ack && ins_rsp_i.err)) else $error("ins port ack and err together");
  a_dat_excl: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    !(dat_rsp_i.ack && dat_rsp_i.err)) else $error("dat port ack and err together");

  // Response answers a live request of the previous cycle
  a_ins_live: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    (ins_rsp_i.ack || ins_rsp_i.err) |-> $past(ins_req_i.cyc && ins_req_i.stb))
    else $error("ins port response without cyc and stb");
  a_dat_live: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    (dat_rsp_i.ack || dat_rsp_i.err) |-> $past(dat_req_i.cyc && dat_req_i.stb))
    else $error("dat port response without cyc and stb");

  // Only the owner hears the bus
  a_one_port: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    !((ins_rsp_i.ack || ins_rsp_i.err) && (dat_rsp_i.ack || dat_rsp_i.err)))
    else $error("both ports answered in one cycle");

endmodule

bind wb_mem_subsys wb_mem_subsys_props u_props (
  .HCLK      ( HCLK      ),
  .rst_n_i   ( rst_n_i   ),
  .ins_req_i ( ins_req_i ),
  .ins_rsp_i ( ins_rsp_o ),
  .dat_req_i ( dat_req_i ),
  .dat_rsp_i ( dat_rsp_o )
);

`default_nettype wire
